/* miss_unit.f */
source/miss_pkg.sv
source/mshr_queue_if.sv
source/mshr_queue.sv
source/mshr.sv
source/l2_issue.sv
source/miss_unit.sv
testbench/miss_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the miss_unit testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert \
    --top-module miss_unit_tb \
    -f miss_unit.f \
    --Mdir "$build_dir" -o miss_unit_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

"./$build_dir/miss_unit_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Finished with no errors" "$log_file"; then
    exit 0
fi
echo "simulation reported failures, see $log_file"
exit 1

/* source/l2_issue.sv */
`timescale 1ns/1ps

module l2_issue (
    input  logic            clk,
    input  logic            rst,
    input  logic            l2_ready,
    output logic            l2_req,
    output logic            l2_req_store,
    output miss_pkg::addr_t l2_req_addr,
    mshr_queue_if.issue     iq
);

    miss_pkg::ptr_t       issue_ptr;
    miss_pkg::ptr_t       req_idx;   // slot behind the current request
    miss_pkg::entry_vec_t issued;
    logic                 send;

    assign iq.rd_idx = issue_ptr;

    // next entry in allocation order, not yet sent
    assign send = l2_ready && iq.occupied[issue_ptr] && !issued[issue_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            issue_ptr <= '0;
            req_idx   <= '0;
            issued    <= '0;
            l2_req    <= 1'b0;
        end else begin
            l2_req <= send;  // one cycle per entry
            if (send) begin
                issued[issue_ptr] <= 1'b1;
                req_idx           <= issue_ptr;
                issue_ptr         <= issue_ptr + 1'b1;
            end
            // slot free again once the head retires
            if (iq.pop) begin
                issued[iq.head] <= 1'b0;
            end
        end
    end

    // request payload
    always_ff @(posedge clk) begin
        if (send) begin
            l2_req_addr  <= {iq.rd_entry.line, {miss_pkg::line_off_w{1'b0}}};
            l2_req_store <= iq.rd_entry.store;
        end
    end

    // an entry cannot retire before its request has gone out
    a_req_occupied: assert property (
        @(posedge clk) disable iff (rst)
        l2_req |-> iq.occupied[req_idx]
    ) else $error("l2_issue: request for empty slot %0d", req_idx);

endmodule

/* source/miss_pkg.sv */
package miss_pkg;

    // queue geometry
    localparam int mshr_depth = 8;
    localparam int mshr_ptr_w = $clog2(mshr_depth); // 3

    // address split
    localparam int addr_w     = 32;
    localparam int line_off_w = 4;                    // 16-byte lines
    localparam int line_w     = addr_w - line_off_w;  // 28
    localparam int op_w       = 3;

    typedef logic [addr_w-1:0]     addr_t;
    typedef logic [line_w-1:0]     line_t;
    typedef logic [mshr_ptr_w-1:0] ptr_t;
    typedef logic [op_w-1:0]       op_t;

    // only this code marks an entry as a store, anything else is a load
    localparam op_t op_store = 3'd3;

    // one pending miss, 30 bits
    typedef struct packed {
        line_t line;
        logic  store;
        logic  done;   // L2 has answered
    } entry_t;

    // one bit per entry: occupancy, match and mark
    typedef logic [mshr_depth-1:0] entry_vec_t;

endpackage

/* source/miss_unit.sv */
`timescale 1ns/1ps

module miss_unit (
    input  logic            clk,
    input  logic            rst,
    input  logic            alloc,
    input  miss_pkg::op_t   op,
    input  miss_pkg::addr_t addr,
    input  logic            l2_valid,
    input  logic            l2_store,
    input  miss_pkg::addr_t l2_addr,
    input  logic            l2_ready,
    output logic            l2_req,
    output logic            l2_req_store,
    output miss_pkg::addr_t l2_req_addr,
    output logic            mshr_hit,
    output miss_pkg::ptr_t  mshr_hit_ptr,
    output miss_pkg::ptr_t  mshr_wr_ptr,
    output logic            mshr_fin,
    output miss_pkg::ptr_t  mshr_fin_ptr,
    output logic            mshr_full
);

    mshr_queue_if mq_if ();

    mshr_queue u_queue (
        .clk (clk),
        .rst (rst),
        .q   (mq_if)
    );

    mshr u_mshr (
        .clk          (clk),
        .rst          (rst),
        .alloc        (alloc),
        .op           (op),
        .addr         (addr),
        .l2_valid     (l2_valid),
        .l2_store     (l2_store),
        .l2_addr      (l2_addr),
        .mshr_hit     (mshr_hit),
        .mshr_hit_ptr (mshr_hit_ptr),
        .mshr_wr_ptr  (mshr_wr_ptr),
        .mshr_fin     (mshr_fin),
        .mshr_fin_ptr (mshr_fin_ptr),
        .q            (mq_if)
    );

    l2_issue u_issue (
        .clk          (clk),
        .rst          (rst),
        .l2_ready     (l2_ready),
        .l2_req       (l2_req),
        .l2_req_store (l2_req_store),
        .l2_req_addr  (l2_req_addr),
        .iq           (mq_if)
    );

    assign mshr_full = mq_if.full;

endmodule

/* source/mshr.sv */
`timescale 1ns/1ps

module mshr (
    input  logic              clk,
    input  logic              rst,
    input  logic              alloc,
    input  miss_pkg::op_t     op,
    input  miss_pkg::addr_t   addr,
    input  logic              l2_valid,
    input  logic              l2_store,
    input  miss_pkg::addr_t   l2_addr,
    output logic              mshr_hit,
    output miss_pkg::ptr_t    mshr_hit_ptr,
    output miss_pkg::ptr_t    mshr_wr_ptr,
    output logic              mshr_fin,
    output miss_pkg::ptr_t    mshr_fin_ptr,
    mshr_queue_if.mshr        q
);

    // one-hot to index, 0 for an empty vector
    function automatic miss_pkg::ptr_t onehot_idx(input miss_pkg::entry_vec_t v);
        miss_pkg::ptr_t idx;
        idx = '0;
        for (int i = 0; i < miss_pkg::mshr_depth; i++) begin
            if (v[i]) begin
                idx = idx | miss_pkg::ptr_t'(i);
            end
        end
        return idx;
    endfunction

    miss_pkg::line_t      req_line;
    miss_pkg::line_t      rsp_line;
    logic                 req_store;
    miss_pkg::entry_vec_t live;
    miss_pkg::entry_vec_t hit_vec;
    miss_pkg::entry_vec_t match_vec;
    miss_pkg::entry_vec_t mark_vec;

    assign req_line  = addr[miss_pkg::addr_w-1:miss_pkg::line_off_w];
    assign rsp_line  = l2_addr[miss_pkg::addr_w-1:miss_pkg::line_off_w];
    assign req_store = (op == miss_pkg::op_store);

    // new entry goes in not done
    assign q.wr       = alloc;
    assign q.wr_entry = '{line: req_line, store: req_store, done: 1'b0};

    // tag compare, pending entries only
    always_comb begin
        for (int i = 0; i < miss_pkg::mshr_depth; i++) begin
            live[i]      = q.occupied[i] && !q.entries[i].done;
            hit_vec[i]   = live[i] && (q.entries[i].line == req_line)
                           && (q.entries[i].store == req_store);
            match_vec[i] = live[i] && (q.entries[i].line == rsp_line)
                           && (q.entries[i].store == l2_store);
        end
    end

    assign mark_vec = l2_valid ? match_vec : '0;
    assign q.mark   = mark_vec;

    assign mshr_hit     = |hit_vec;
    assign mshr_hit_ptr = onehot_idx(hit_vec);
    assign mshr_fin     = |mark_vec;
    assign mshr_fin_ptr = onehot_idx(mark_vec);

    // follows the queue tail
    always_ff @(posedge clk) begin
        if (rst) begin
            mshr_wr_ptr <= '0;
        end else if (alloc) begin
            mshr_wr_ptr <= mshr_wr_ptr + 1'b1;
        end
    end

    // a line and kind is never pending twice
    a_hit_onehot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(hit_vec)
    ) else $error("mshr: several entries hit");

    // every response belongs to exactly one outstanding miss
    a_rsp_match: assert property (
        @(posedge clk) disable iff (rst)
        l2_valid |-> $onehot(match_vec)
    ) else $error("mshr: L2 response matches %0d entries", $countones(match_vec));

endmodule

/* source/mshr_queue.sv */
`timescale 1ns/1ps

module mshr_queue (
    input logic         clk,
    input logic         rst,
    mshr_queue_if.queue q
);

    miss_pkg::entry_t     mem [miss_pkg::mshr_depth];
    miss_pkg::entry_vec_t occ;
    miss_pkg::ptr_t       head_ptr;
    miss_pkg::ptr_t       tail_ptr;
    logic                 retire;
    logic                 full;

    // head leaves once L2 has answered it
    assign retire = occ[head_ptr] && mem[head_ptr].done;
    assign full   = &occ;

    // entry storage
    always_ff @(posedge clk) begin
        if (q.wr) begin
            mem[tail_ptr] <= q.wr_entry;
        end
        // done flags are set in place, any slot
        for (int i = 0; i < miss_pkg::mshr_depth; i++) begin
            if (q.mark[i] && occ[i]) begin
                mem[i].done <= 1'b1;
            end
        end
    end

    // occupancy and pointers
    always_ff @(posedge clk) begin
        if (rst) begin
            occ      <= '0;
            head_ptr <= '0;
            tail_ptr <= '0;
        end else begin
            if (q.wr) begin
                occ[tail_ptr] <= 1'b1;
                tail_ptr      <= tail_ptr + 1'b1;  // wraps 7 -> 0
            end
            if (retire) begin
                occ[head_ptr] <= 1'b0;
                head_ptr      <= head_ptr + 1'b1;
            end
        end
    end

    assign q.entries  = mem;
    assign q.occupied = occ;
    assign q.head     = head_ptr;
    assign q.full     = full;
    assign q.pop      = retire;
    assign q.rd_entry = mem[q.rd_idx];

    // cache must hold off allocs while the MSHR reports full
    a_no_wr_full: assert property (
        @(posedge clk) disable iff (rst)
        q.wr |-> !full
    ) else $error("mshr_queue: write while full");

    // responses only ever mark live entries
    a_mark_occupied: assert property (
        @(posedge clk) disable iff (rst)
        (q.mark & ~occ) == '0
    ) else $error("mshr_queue: mark on empty slot");

endmodule

/* source/mshr_queue_if.sv */
`timescale 1ns/1ps

interface mshr_queue_if;
    logic                 wr;       // allocate at tail
    miss_pkg::entry_t     wr_entry;
    miss_pkg::entry_vec_t mark;     // set done flags
    logic                 pop;      // head retires this cycle
    miss_pkg::entry_t     entries [miss_pkg::mshr_depth];
    miss_pkg::entry_vec_t occupied;
    miss_pkg::ptr_t       head;
    logic                 full;
    miss_pkg::ptr_t       rd_idx;   // issue read port
    miss_pkg::entry_t     rd_entry;

    modport mshr (
        output wr, wr_entry, mark,
        input  entries, occupied
    );

    modport queue (
        input  wr, wr_entry, mark, rd_idx,
        output entries, occupied, head, full, pop, rd_entry
    );

    modport issue (
        input  occupied, head, pop, rd_entry,
        output rd_idx
    );
endinterface

/* testbench/miss_unit_tb.sv */
`timescale 1ns/1ps

module miss_unit_tb;

    logic            clk;
    logic            rst;
    logic            alloc;
    miss_pkg::op_t   op;
    miss_pkg::addr_t addr;
    logic            l2_valid;
    logic            l2_store;
    miss_pkg::addr_t l2_addr;
    logic            l2_ready;
    logic            l2_req;
    logic            l2_req_store;
    miss_pkg::addr_t l2_req_addr;
    logic            mshr_hit;
    miss_pkg::ptr_t  mshr_hit_ptr;
    miss_pkg::ptr_t  mshr_wr_ptr;
    logic            mshr_fin;
    miss_pkg::ptr_t  mshr_fin_ptr;
    logic            mshr_full;

    // reference model of the queue
    miss_pkg::line_t      m_line [miss_pkg::mshr_depth];
    miss_pkg::entry_vec_t m_store;
    miss_pkg::entry_vec_t m_done;
    miss_pkg::entry_vec_t m_occ;
    miss_pkg::entry_vec_t m_issued;
    miss_pkg::ptr_t       m_head;
    miss_pkg::ptr_t       m_tail;
    miss_pkg::ptr_t       m_iptr;

    logic            exp_req;
    logic            exp_req_store;
    miss_pkg::addr_t exp_req_addr;
    logic [32:0]     sent_q [$];   // {store, addr} of DUT requests not yet checked

    int error_count;
    int test_errors;
    int test_count;
    int failed_tests;

    miss_unit u_miss_unit (
        .clk          (clk),
        .rst          (rst),
        .alloc        (alloc),
        .op           (op),
        .addr         (addr),
        .l2_valid     (l2_valid),
        .l2_store     (l2_store),
        .l2_addr      (l2_addr),
        .l2_ready     (l2_ready),
        .l2_req       (l2_req),
        .l2_req_store (l2_req_store),
        .l2_req_addr  (l2_req_addr),
        .mshr_hit     (mshr_hit),
        .mshr_hit_ptr (mshr_hit_ptr),
        .mshr_wr_ptr  (mshr_wr_ptr),
        .mshr_fin     (mshr_fin),
        .mshr_fin_ptr (mshr_fin_ptr),
        .mshr_full    (mshr_full)
    );

    always #2 clk = ~clk;

    task automatic report_mismatch(string msg);
        error_count++;
        test_errors++;
        $display("Error at %0d ns: %s", $time, msg);
    endtask

    task automatic note_failure(string msg);
        error_count++;
        test_errors++;
        $display("Test problem at %0d ns: %s", $time, msg);
    endtask

    task automatic finish_test(string name);
        string verdict;
        verdict = "ok";
        test_count++;
        if (test_errors != 0) begin
            failed_tests++;
            verdict = "FAILED";
        end
        $display("test %0d %s: %s", test_count, name, verdict);
        test_errors = 0;
    endtask

    function automatic miss_pkg::line_t line_of(miss_pkg::addr_t a);
        return a[miss_pkg::addr_w-1:miss_pkg::line_off_w];
    endfunction

    // pending entries of the model with this line and kind
    function automatic miss_pkg::entry_vec_t model_match(miss_pkg::line_t ln, logic st);
        miss_pkg::entry_vec_t v;
        v = '0;
        for (int i = 0; i < miss_pkg::mshr_depth; i++) begin
            v[i] = m_occ[i] && !m_done[i] && (m_line[i] == ln) && (m_store[i] == st);
        end
        return v;
    endfunction

    function automatic miss_pkg::ptr_t first_index(miss_pkg::entry_vec_t v);
        miss_pkg::ptr_t idx;
        idx = '0;
        for (int i = miss_pkg::mshr_depth - 1; i >= 0; i--) begin
            if (v[i]) begin
                idx = miss_pkg::ptr_t'(i);
            end
        end
        return idx;
    endfunction

    // one clock edge of the model on pre-edge state
    task automatic update_model();
        miss_pkg::entry_vec_t marks;
        logic retire;
        logic send;
        marks  = l2_valid ? model_match(line_of(l2_addr), l2_store) : '0;
        retire = m_occ[m_head] && m_done[m_head];
        send   = l2_ready && m_occ[m_iptr] && !m_issued[m_iptr];
        exp_req = send;
        if (send) begin
            exp_req_addr     = {m_line[m_iptr], 4'h0};
            exp_req_store    = m_store[m_iptr];
            m_issued[m_iptr] = 1'b1;
            m_iptr           = m_iptr + 3'd1;
        end
        m_done = m_done | marks;
        if (alloc) begin
            m_line[m_tail]  = line_of(addr);
            m_store[m_tail] = (op == miss_pkg::op_store);
            m_done[m_tail]  = 1'b0;
            m_occ[m_tail]   = 1'b1;
            m_tail          = m_tail + 3'd1;
        end
        if (retire) begin
            m_occ[m_head]    = 1'b0;
            m_issued[m_head] = 1'b0;
            m_head           = m_head + 3'd1;
        end
    endtask

    // model steps at the edge before registered outputs are checked
    task automatic advance_cycle();
        @(posedge clk);
        update_model();
        #1;
        assert (l2_req === exp_req) else
            report_mismatch($sformatf("l2_req is %b, expected %b", l2_req, exp_req));
        if (exp_req) begin
            assert (l2_req_addr === exp_req_addr && l2_req_store === exp_req_store) else
                report_mismatch($sformatf("request %h store %b, expected %h store %b",
                    l2_req_addr, l2_req_store, exp_req_addr, exp_req_store));
        end
        if (l2_req === 1'b1) begin
            sent_q.push_back({l2_req_store, l2_req_addr});
        end
        assert (mshr_wr_ptr === m_tail) else
            report_mismatch($sformatf("mshr_wr_ptr is %0d, expected %0d", mshr_wr_ptr, m_tail));
        assert (mshr_full === &m_occ) else
            report_mismatch($sformatf("mshr_full is %b, expected %b", mshr_full, &m_occ));
    endtask

    task automatic idle_inputs(logic ready);
        alloc    = 1'b0;
        l2_valid = 1'b0;
        l2_ready = ready;
    endtask

    task automatic do_alloc(miss_pkg::op_t o, miss_pkg::addr_t a, miss_pkg::ptr_t ew);
        advance_cycle();
        idle_inputs(1'b0);
        if (&m_occ) begin
            note_failure("alloc requested while the MSHR is full");
        end else begin
            alloc = 1'b1;
            op    = o;
            addr  = a;
            #1;
            assert (m_tail == ew) else
                report_mismatch($sformatf("model write slot %0d, data file %0d", m_tail, ew));
            assert (mshr_wr_ptr === ew) else
                report_mismatch($sformatf("mshr_wr_ptr is %0d, expected %0d", mshr_wr_ptr, ew));
        end
        finish_test($sformatf("alloc %h", a));
    endtask

    task automatic probe(miss_pkg::op_t o, miss_pkg::addr_t a, logic eh, miss_pkg::ptr_t ei);
        miss_pkg::entry_vec_t mv;
        advance_cycle();
        idle_inputs(1'b0);
        op   = o;
        addr = a;
        #1;
        mv = model_match(line_of(a), o == miss_pkg::op_store);
        assert ((|mv) == eh && first_index(mv) == ei) else
            report_mismatch($sformatf("model hit %b idx %0d, data file %b idx %0d",
                |mv, first_index(mv), eh, ei));
        assert (mshr_hit === eh && mshr_hit_ptr === ei) else
            report_mismatch($sformatf("probe %h op %0d: hit %b idx %0d, expected %b idx %0d",
                a, o, mshr_hit, mshr_hit_ptr, eh, ei));
        finish_test($sformatf("probe %h", a));
    endtask

    task automatic respond(logic st, miss_pkg::addr_t a, miss_pkg::ptr_t ei);
        miss_pkg::entry_vec_t mv;
        advance_cycle();
        idle_inputs(1'b0);
        mv = model_match(line_of(a), st);
        if ($onehot(mv) && m_issued[first_index(mv)]) begin
            l2_valid = 1'b1;
            l2_store = st;
            l2_addr  = a;
            #1;
            assert (first_index(mv) == ei) else
                report_mismatch($sformatf("model finish idx %0d, data file %0d",
                    first_index(mv), ei));
            assert (mshr_fin === 1'b1 && mshr_fin_ptr === ei) else
                report_mismatch($sformatf("response %h: fin %b idx %0d, expected 1 idx %0d",
                    a, mshr_fin, mshr_fin_ptr, ei));
        end else begin
            note_failure("response does not match exactly one issued entry");
        end
        finish_test($sformatf("response %h", a));
    endtask

    task automatic expect_issue(logic st, miss_pkg::addr_t a);
        int          waited;
        logic [32:0] got;
        waited = 0;
        while (sent_q.size() == 0 && waited < 50) begin
            advance_cycle();
            idle_inputs(1'b1);
            waited++;
        end
        if (sent_q.size() == 0) begin
            note_failure("no L2 request came out within 50 cycles");
        end else begin
            got = sent_q.pop_front();
            assert (got == {st, a}) else
                report_mismatch($sformatf("issued %h store %b, expected %h store %b",
                    got[31:0], got[32], a, st));
        end
        finish_test($sformatf("issue %h", a));
    endtask

    // idle gap with random l2_ready
    task automatic wait_cycles(int n);
        logic [31:0] rnd;
        for (int i = 0; i < n; i++) begin
            advance_cycle();
            rnd = $urandom;
            idle_inputs(rnd[0]);
        end
        finish_test($sformatf("wait %0d", n));
    endtask

    initial begin
        int          fd;
        int          nf;
        string       text;
        logic [7:0]  cmd;
        logic [31:0] f0;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        void'($urandom(32'h5a1e9a4b));
        clk      = 1'b0;
        rst      = 1'b1;
        op       = '0;
        addr     = '0;
        l2_store = 1'b0;
        l2_addr  = '0;
        idle_inputs(1'b0);
        error_count  = 0;
        test_errors  = 0;
        test_count   = 0;
        failed_tests = 0;
        m_store  = '0;
        m_done   = '0;
        m_occ    = '0;
        m_issued = '0;
        m_head   = '0;
        m_tail   = '0;
        m_iptr   = '0;
        exp_req  = 1'b0;
        for (int i = 0; i < miss_pkg::mshr_depth; i++) begin
            m_line[i] = '0;
        end

        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        #1;
        assert (!mshr_hit && !mshr_fin && !l2_req && !mshr_full) else
            report_mismatch("status outputs not low after reset");
        assert (mshr_wr_ptr === '0 && mshr_hit_ptr === '0 && mshr_fin_ptr === '0) else
            report_mismatch("pointers not zero after reset");
        finish_test("reset");

        fd = $fopen("testbench/miss_unit_testdata.txt", "r");
        if (fd == 0) begin
            note_failure("could not open testbench/miss_unit_testdata.txt");
        end else begin
            while (!$feof(fd)) begin
                text = "";
                nf = $fgets(text, fd);
                if (nf > 1 && text.getc(0) != "#" && text.getc(0) != "\n") begin
                    cmd = text.getc(0);
                    f0 = '0;
                    f1 = '0;
                    f2 = '0;
                    f3 = '0;
                    nf = $sscanf(text.substr(1, text.len() - 1), "%h %h %h %h", f0, f1, f2, f3);
                    case (cmd)
                        "A": do_alloc(f0[2:0], f1, f2[2:0]);
                        "H": probe(f0[2:0], f1, f2[0], f3[2:0]);
                        "R": respond(f0[0], f1, f2[2:0]);
                        "I": expect_issue(f0[0], f1);
                        "W": wait_cycles(f0);
                        default: note_failure($sformatf("unknown command in data file: %s", text));
                    endcase
                end
            end
            $fclose(fd);
        end

        // let the last inputs reach the DUT
        for (int i = 0; i < 4; i++) begin
            advance_cycle();
            idle_inputs(1'b0);
        end
        finish_test("drain");

        $display("%0d tests, %0d failed, %0d errors", test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* testbench/miss_unit_testdata.txt */
# A op addr wr_ptr | H op addr hit idx | R store addr fin_idx
# I store req_addr | W cycles   (all fields hex)
A 1 00001000 0
A 3 00002040 1
A 1 00003080 2
A 3 00001000 3
A 0 000040c0 4
A 3 00005100 5
A 2 00006140 6
A 3 00007180 7
H 1 00001008 1 0
H 3 00001000 1 3
H 5 00002040 0 0
H 3 0000204c 1 1
H 1 00008000 0 0
H 2 000040c4 1 4
I 0 00001000
I 1 00002040
W 6
I 0 00003080
I 1 00001000
I 0 000040c0
W 5
I 1 00005100
I 0 00006140
I 1 00007180
R 1 00005100 5
H 3 00005100 0 0
R 0 00003080 2
R 1 00002040 1
W 3
R 0 00001008 0
W 4
A 3 00009000 0
A 1 0000a000 1
A 6 0000b000 2
H 3 00009000 1 0
H 1 00001000 0 0
H 3 00001000 1 3
I 1 00009000
I 0 0000a000
I 0 0000b000
R 1 00001000 3
R 0 000040c0 4
R 1 00009000 0
R 0 00006140 6
R 1 00007180 7
R 0 0000a000 1
R 0 0000b000 2
W 8
